//--- logic/mvau_pkg.sv
// MVAU sizes, counter widths and lane types
// Activation, weight and output beat types shared by all blocks
package mvau_pkg;

   // Activation lanes per beat
   localparam int MVAU_SIMD = 2;
   // Output channels per group
   localparam int MVAU_PE = 2;
   // Beats per input vector, also input buffer depth
   localparam int MVAU_SF = 4;
   // Output channel groups per vector
   localparam int MVAU_NF = 3;

   // Counter widths, at least one bit
   localparam int MVAU_SF_W = (MVAU_SF > 1) ? $clog2(MVAU_SF) : 1;
   localparam int MVAU_NF_W = (MVAU_NF > 1) ? $clog2(MVAU_NF) : 1;

   // Signed lane widths
   localparam int MVAU_ACT_W = 4;
   localparam int MVAU_WGT_W = 4;
   localparam int MVAU_ACC_W = 16;

   // Single lanes, signed so element selects keep their sign
   typedef logic signed [MVAU_ACT_W-1:0] act_lane_t;
   typedef logic signed [MVAU_WGT_W-1:0] wgt_lane_t;
   typedef logic signed [MVAU_ACC_W-1:0] acc_t;

   // One activation beat, SIMD lanes
   typedef act_lane_t [MVAU_SIMD-1:0] act_beat_t;

   // One weight beat, a SIMD row for every PE
   typedef wgt_lane_t [MVAU_PE-1:0][MVAU_SIMD-1:0] wgt_beat_t;

   // One output beat, one sum per PE
   typedef acc_t [MVAU_PE-1:0] out_beat_t;

endpackage

//--- logic/mvau_ctrl_if.sv
// Control bundle from the stream control block to buffer and PE array
// Modports for the control block, the input buffer and the PE array
interface mvau_ctrl_if;
   import mvau_pkg::*;

   // Input buffer write and read enables
   logic ib_wen;
   logic ib_ren;
   // Buffer address, position inside the SF group
   logic [MVAU_SF_W-1:0] sf_cnt;
   // A beat enters the PE array this cycle
   logic do_stream;
   // Previous edge took the last beat of an SF group
   logic sf_last;

   modport ctrl (
      output ib_wen,
      output ib_ren,
      output sf_cnt,
      output do_stream,
      output sf_last
   );

   // Read path needs only the write enable
   modport buffer (input ib_wen, input sf_cnt);

   modport pe (input do_stream, input sf_last);

endinterface

//--- logic/mvau_stream_control.sv
// Input stream control for the MVAU
// Idle, write and replay FSM with SF and NF counters
module mvau_stream_control (
   input  logic      aclk,
   input  logic      aresetn,
   input  logic      in_v,
   output logic      in_rdy,
   output logic      wgt_rdy,
   mvau_ctrl_if.ctrl ctrl
);
   import mvau_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_REPLAY} state_t;

   state_t               state;
   state_t               state_nxt;
   logic                 ap_start;
   logic                 inp_active;
   logic                 ib_wen;
   logic                 ib_ren;
   logic                 do_stream;
   logic                 sf_full;
   logic                 nf_at_last;
   logic                 write_done;
   logic                 replay_done;
   logic [MVAU_SF_W-1:0] sf_cnt;
   logic [MVAU_NF_W-1:0] nf_cnt;

   // Beat handshake on the input stream
   assign inp_active = in_rdy & in_v;

   // Last beat of an SF group goes through this cycle
   assign sf_full    = do_stream & (sf_cnt == MVAU_SF_W'(MVAU_SF - 1));
   assign nf_at_last = (nf_cnt == MVAU_NF_W'(MVAU_NF - 1));
   // Whole vector written, or last replayed group finished
   assign write_done  = sf_full & (state != ST_REPLAY);
   assign replay_done = sf_full & nf_at_last & (state == ST_REPLAY);

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_REPLAY: begin
            if (replay_done) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            // Single group needs no replay
            if (write_done) begin
               state_nxt = (MVAU_NF > 1) ? ST_REPLAY : ST_IDLE;
            end else if (inp_active) begin
               state_nxt = ST_WRITE;
            end
         end
      endcase
   end

   // Write on live beats, read back without gaps during replay
   always_comb begin
      ib_wen    = 1'b0;
      ib_ren    = 1'b0;
      do_stream = 1'b0;
      case (state)
         ST_REPLAY: begin
            ib_ren    = 1'b1;
            do_stream = 1'b1;
         end
         default: begin
            ib_wen    = inp_active;
            do_stream = inp_active;
         end
      endcase
   end

   // High only in the first cycle out of reset
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         ap_start <= 1'b1;
      end else begin
         ap_start <= 1'b0;
      end
   end

   // Input back-pressure while the buffer is replayed
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         in_rdy <= 1'b0;
      end else if (ap_start || replay_done) begin
         in_rdy <= 1'b1;
      end else if (write_done && (MVAU_NF > 1)) begin
         in_rdy <= 1'b0;
      end
   end

   // Buffer address, wraps at the end of each group
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         sf_cnt <= '0;
      end else if (sf_full) begin
         sf_cnt <= '0;
      end else if (do_stream) begin
         sf_cnt <= sf_cnt + 1'b1;
      end
   end

   // Group index within the current vector
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         nf_cnt <= '0;
      end else if (sf_full) begin
         nf_cnt <= nf_at_last ? '0 : nf_cnt + 1'b1;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         ctrl.sf_last <= 1'b0;
      end else begin
         ctrl.sf_last <= sf_full;
      end
   end

   assign ctrl.ib_wen    = ib_wen;
   assign ctrl.ib_ren    = ib_ren;
   assign ctrl.sf_cnt    = sf_cnt;
   assign ctrl.do_stream = do_stream;

   // Weight source steps with every streamed beat
   assign wgt_rdy = do_stream;

endmodule

//--- logic/mvau_input_buffer.sv
// SF-deep activation buffer
// Live beats pass straight through while being written
module mvau_input_buffer (
   input  logic                aclk,
   input  mvau_pkg::act_beat_t in_data,
   mvau_ctrl_if.buffer         ctrl,
   output mvau_pkg::act_beat_t act
);
   import mvau_pkg::*;

   // One entry per beat of the vector
   act_beat_t mem [MVAU_SF];

   always_ff @(posedge aclk) begin
      if (ctrl.ib_wen) begin
         mem[ctrl.sf_cnt] <= in_data;
      end
   end

   // First group computes on live data, later groups on stored beats
   always_comb begin
      if (ctrl.ib_wen) begin
         act = in_data;
      end else begin
         act = mem[ctrl.sf_cnt];
      end
   end

endmodule

//--- logic/mvau_pe_array.sv
// PE array of the MVAU
// SIMD products and lane sum, accumulation over SF beats, output pulse
module mvau_pe_array (
   input  logic                aclk,
   input  logic                aresetn,
   input  mvau_pkg::act_beat_t act,
   input  mvau_pkg::wgt_beat_t wgt_data,
   mvau_ctrl_if.pe             ctrl,
   output mvau_pkg::out_beat_t out_data,
   output logic                out_v
);
   import mvau_pkg::*;

   out_beat_t lane_sum;
   out_beat_t sum_q;
   out_beat_t acc;
   out_beat_t acc_sum;
   logic      s1_v;

   // Signed dot product of the beat with each PE weight row
   always_comb begin
      acc_t sum;
      for (int p = 0; p < MVAU_PE; p++) begin
         sum = '0;
         for (int s = 0; s < MVAU_SIMD; s++) begin
            sum = sum + $signed(act[s]) * $signed(wgt_data[p][s]);
         end
         lane_sum[p] = sum;
      end
   end

   // Stage 1, lane sums of the streamed beat
   always_ff @(posedge aclk) begin
      if (ctrl.do_stream) begin
         sum_q <= lane_sum;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         s1_v <= 1'b0;
      end else begin
         s1_v <= ctrl.do_stream;
      end
   end

   // Running sum including the beat in stage 1
   always_comb begin
      for (int p = 0; p < MVAU_PE; p++) begin
         acc_sum[p] = acc[p] + sum_q[p];
      end
   end

   // Stage 2, cleared at group end so the next group starts from its first sum
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         acc <= '0;
      end else if (s1_v) begin
         acc <= ctrl.sf_last ? '0 : acc_sum;
      end
   end

   // Final group sums
   always_ff @(posedge aclk) begin
      if (s1_v && ctrl.sf_last) begin
         out_data <= acc_sum;
      end
   end

   // One cycle pulse per group, no back-pressure
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         out_v <= 1'b0;
      end else begin
         out_v <= s1_v & ctrl.sf_last;
      end
   end

endmodule

//--- logic/mvau_stream.sv
// MVAU streaming unit top level
// Control block, input buffer and PE array on plain stream ports
module mvau_stream (
   input  logic                aclk,
   input  logic                aresetn,
   // Activation input stream
   input  mvau_pkg::act_beat_t in_data,
   input  logic                in_v,
   output logic                in_rdy,
   // Weight stream, ready only
   input  mvau_pkg::wgt_beat_t wgt_data,
   output logic                wgt_rdy,
   // Output sums, single cycle pulses
   output mvau_pkg::out_beat_t out_data,
   output logic                out_v
);
   import mvau_pkg::*;

   // Activation beat into the PE array
   act_beat_t act;

   mvau_ctrl_if u_ctrl_if ();

   mvau_stream_control u_mvau_stream_control (
      .aclk    (aclk),
      .aresetn (aresetn),
      .in_v    (in_v),
      .in_rdy  (in_rdy),
      .wgt_rdy (wgt_rdy),
      .ctrl    (u_ctrl_if.ctrl)
   );

   mvau_input_buffer u_mvau_input_buffer (
      .aclk    (aclk),
      .in_data (in_data),
      .ctrl    (u_ctrl_if.buffer),
      .act     (act)
   );

   mvau_pe_array u_mvau_pe_array (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .act      (act),
      .wgt_data (wgt_data),
      .ctrl     (u_ctrl_if.pe),
      .out_data (out_data),
      .out_v    (out_v)
   );

endmodule

//--- verif/mvau_stream_assertions.sv
// Concurrent checks on the MVAU stream control protocol
// Bound to the control block
module mvau_stream_assertions (
   input logic aclk,
   input logic aresetn,
   input logic in_rdy,
   input logic wgt_rdy,
   input logic ib_wen,
   input logic ib_ren
);
   import mvau_pkg::*;

   // Count of failed checks
   int fail_cnt = 0;

   // Replay starts right after the final beat is written
   replay_after_write: assert property (@(posedge aclk) disable iff (!aresetn)
                                        $rose(ib_ren) |-> $past(ib_wen))
      else begin
         fail_cnt++;
         $error("replay started without a buffer write in the cycle before");
      end

   // All later groups replayed back to back, weights consumed on every beat
   replay_length: assert property (@(posedge aclk) disable iff (!aresetn)
                                   $rose(ib_ren) |->
                                   (ib_ren && wgt_rdy)[*(MVAU_NF - 1) * MVAU_SF] ##1 !ib_ren)
      else begin
         fail_cnt++;
         $error("replay did not run for the full set of groups without gaps");
      end

   // Input held off while the buffer is replayed
   no_input_in_replay: assert property (@(posedge aclk) disable iff (!aresetn) ib_ren |-> !in_rdy)
      else begin
         fail_cnt++;
         $error("in_rdy high during replay");
      end

endmodule

//--- verif/mvau_stream_tb.sv
// Testbench for the MVAU stream unit
// Clock and reset, file driven vectors, weight stream model, output checker, watchdog
module mvau_stream_tb;
   import mvau_pkg::*;

   // Test file layout, word 0 is the test count
   localparam int MAX_TESTS  = 32;
   localparam int WGT_BEATS  = MVAU_NF * MVAU_SF;
   localparam int TEST_BASE  = 1 + WGT_BEATS;
   localparam int TEST_WORDS = MVAU_SF + 1 + MVAU_NF;

   logic      aclk;
   logic      aresetn;
   act_beat_t in_data;
   logic      in_v;
   logic      in_rdy;
   wgt_beat_t wgt_data;
   logic      wgt_rdy;
   out_beat_t out_data;
   logic      out_v;

   logic [31:0] tests_mem [TEST_BASE + MAX_TESTS * TEST_WORDS];
   wgt_beat_t   weights [WGT_BEATS];
   int          num_tests;
   logic        loaded = 1'b0;
   integer      seed;
   int          wgt_idx;
   out_beat_t   exp_q [$];
   // Handshake and pulse counts
   int          beat_cnt = 0;
   int          wgt_total = 0;
   int          vec_wgt = 0;
   int          out_cnt = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   // Replay window after the last beat of a vector
   int          replay_left = 0;
   logic        rise_due = 1'b0;

   mvau_stream u_mvau_stream (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .in_data  (in_data),
      .in_v     (in_v),
      .in_rdy   (in_rdy),
      .wgt_data (wgt_data),
      .wgt_rdy  (wgt_rdy),
      .out_data (out_data),
      .out_v    (out_v)
   );

   bind mvau_stream_control mvau_stream_assertions u_mvau_stream_assertions (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_rdy    (in_rdy),
      .wgt_rdy   (wgt_rdy),
      .ib_wen    (ib_wen),
      .ib_ren    (ib_ren)
   );

   initial aclk = 1'b0;
   always #50 aclk = ~aclk;

   function automatic act_beat_t act_word(input int t, input int b);
      return tests_mem[TEST_BASE + t * TEST_WORDS + b][$bits(act_beat_t)-1:0];
   endfunction

   function automatic logic gap_flag(input int t);
      return tests_mem[TEST_BASE + t * TEST_WORDS + MVAU_SF][0];
   endfunction

   function automatic out_beat_t file_sum(input int t, input int g);
      return tests_mem[TEST_BASE + t * TEST_WORDS + MVAU_SF + 1 + g];
   endfunction

   // Signed dot product of vector t with the weight rows of group g
   function automatic out_beat_t group_dot(input int t, input int g);
      out_beat_t res;
      act_beat_t a;
      wgt_beat_t w;
      int        total;
      for (int p = 0; p < MVAU_PE; p++) begin
         total = 0;
         for (int b = 0; b < MVAU_SF; b++) begin
            a = act_word(t, b);
            w = weights[g * MVAU_SF + b];
            for (int s = 0; s < MVAU_SIMD; s++) begin
               total = total + int'(a[s]) * int'(w[p][s]);
            end
         end
         res[p] = total[MVAU_ACC_W-1:0];
      end
      return res;
   endfunction

   task automatic check_count(input string name, input int got, input int want);
      assert (got == want) else begin
         value_errors++;
         $display("error: time %0t, %s: got %0d, expected %0d", $time, name, got, want);
      end
   endtask

   task automatic check_low(input string name, input logic value);
      assert (value === 1'b0) else begin
         value_errors++;
         $display("error: time %0t, %s: got %b, expected 0", $time, name, value);
      end
   endtask

   // One vector, in_v dropped at random when the gap flag is set
   task automatic send_vector(input int t);
      int   b;
      logic gap;
      b = 0;
      while (b < MVAU_SF) begin
         gap = gap_flag(t) && ($random(seed) % 3 == 0);
         in_data <= act_word(t, b);
         in_v    <= !gap;
         @(posedge aclk);
         if (in_v && in_rdy) begin
            b++;
         end
      end
   endtask

   // Ready-only weight source, next beat present by the consuming edge
   always @(posedge aclk) begin
      if (!aresetn) begin
         wgt_idx  <= 0;
         wgt_data <= weights[0];
      end else if (wgt_rdy) begin
         wgt_idx  <= (wgt_idx + 1) % WGT_BEATS;
         wgt_data <= weights[(wgt_idx + 1) % WGT_BEATS];
      end
   end

   // Handshake counts and output checks
   always @(posedge aclk) begin
      out_beat_t want;
      if (aresetn) begin
         // First beat of a new vector closes the count of the previous one
         if (in_v && in_rdy && (beat_cnt % MVAU_SF == 0)) begin
            if (beat_cnt > 0) begin
               check_count("wgt_rdy cycles per vector", vec_wgt, WGT_BEATS);
            end
            vec_wgt = 0;
         end
         if (wgt_rdy) begin
            vec_wgt++;
            wgt_total++;
         end
         // Input held off for all replays, ready again right after them
         if (replay_left > 0) begin
            check_low("in_rdy", in_rdy);
            replay_left--;
            rise_due = (replay_left == 0);
         end else if (rise_due) begin
            assert (in_rdy === 1'b1) else begin
               other_errors++;
               $display("in_rdy did not rise after the last replay beat at time %0t", $time);
            end
            rise_due = 1'b0;
         end
         if (in_v && in_rdy) begin
            beat_cnt++;
            // Last beat of a vector opens its replay window
            if (beat_cnt % MVAU_SF == 0) begin
               replay_left = (MVAU_NF - 1) * MVAU_SF;
            end
         end
         if (out_v) begin
            out_cnt++;
            assert (exp_q.size() > 0) else begin
               other_errors++;
               $display("Output pulse at time %0t with no result pending", $time);
            end
            if (exp_q.size() > 0) begin
               want = exp_q.pop_front();
               assert (out_data == want) else begin
                  value_errors++;
                  $display("error: time %0t, out_data: got %h, expected %h",
                           $time, out_data, want);
               end
            end
         end
      end
   end

   // Limit scales with the test count
   initial begin
      int limit;
      wait (loaded);
      limit = num_tests * MVAU_NF * MVAU_SF * 4 + 50;
      repeat (limit) @(posedge aclk);
      $display("Timeout: run did not finish within %0d clock cycles", limit);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      int        assert_fails;
      out_beat_t calc;
      in_data  = '0;
      in_v     = 1'b0;
      wgt_data = '0;
      aresetn  = 1'b0;
      seed     = 34;
      $readmemh("verif/mvau_stream_tests.txt", tests_mem);
      num_tests = tests_mem[0];
      assert (num_tests >= 1 && num_tests <= MAX_TESTS) else begin
         other_errors++;
         $display("Test file holds no usable test count");
         num_tests = 0;
      end
      for (int i = 0; i < WGT_BEATS; i++) begin
         weights[i] = tests_mem[1 + i][$bits(wgt_beat_t)-1:0];
      end
      // File sums must match the recomputed dot products
      for (int t = 0; t < num_tests; t++) begin
         for (int g = 0; g < MVAU_NF; g++) begin
            calc = group_dot(t, g);
            assert (calc == file_sum(t, g)) else begin
               value_errors++;
               $display("error: time %0t, expected sum %0d/%0d: got %h, expected %h",
                        $time, t, g, file_sum(t, g), calc);
            end
            exp_q.push_back(file_sum(t, g));
         end
      end
      loaded = 1'b1;

      // Five reset edges, outputs held low throughout
      for (int i = 0; i < 5; i++) begin
         @(posedge aclk);
         if (i == 4) begin
            aresetn <= 1'b1;
         end
         @(negedge aclk);
         check_low("in_rdy", in_rdy);
         check_low("wgt_rdy", wgt_rdy);
         check_low("out_v", out_v);
      end
      @(negedge aclk);
      assert (in_rdy === 1'b1) else begin
         other_errors++;
         $display("in_rdy did not rise one cycle after reset release");
      end

      // Vectors back to back
      @(posedge aclk);
      for (int t = 0; t < num_tests; t++) begin
         send_vector(t);
      end
      in_v <= 1'b0;

      wait (out_cnt == num_tests * MVAU_NF);
      repeat (2) @(negedge aclk);
      check_count("wgt_rdy cycles", wgt_total, num_tests * WGT_BEATS);
      check_count("out_v pulses", out_cnt, num_tests * MVAU_NF);
      if (num_tests > 0) begin
         check_count("wgt_rdy cycles per vector", vec_wgt, WGT_BEATS);
      end
      assert_fails = u_mvau_stream.u_mvau_stream_control.u_mvau_stream_assertions.fail_cnt;
      $display("Errors: %0d value, %0d other, %0d assertion",
               value_errors, other_errors, assert_fails);
      if (value_errors + other_errors + assert_fails == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- verif/mvau_stream_tests.txt
// Word 0 test count, then NF*SF weight beats in group order, PE1 lanes in the high byte
// Per test: SF activation beats, in_v gap flag, NF expected sums with PE1 in the high half
4
// Group 0 weights, beats 0 to 3
1234 F0E1 7788 2C5A
// Group 1 weights, one unit lane per beat
0001 0010 0100 1000
// Group 2 weights
FFFF 3333 9D6B 4E2F
// Test 0, vector A without gaps
21 F3 8C 57
0
FF9F005E 00010000 004DFFEA
// Test 1, vector B without gaps
7F 00 A5 18
0
0020004E 0006FFFF 0029FFC7
// Test 2, vector A with random in_v gaps
21 F3 8C 57
1
FF9F005E 00010000 004DFFEA
// Test 3, vector B with random in_v gaps
7F 00 A5 18
1
0020004E 0006FFFF 0029FFC7

//--- vlog.f
logic/mvau_pkg.sv
logic/mvau_ctrl_if.sv
logic/mvau_stream_control.sv
logic/mvau_input_buffer.sv
logic/mvau_pe_array.sv
logic/mvau_stream.sv
verif/mvau_stream_assertions.sv
verif/mvau_stream_tb.sv

//--- Bender.yml
package:
  name: mvau_stream

sources:
  - files:
      - logic/mvau_pkg.sv
      - logic/mvau_ctrl_if.sv
      - logic/mvau_stream_control.sv
      - logic/mvau_input_buffer.sv
      - logic/mvau_pe_array.sv
      - logic/mvau_stream.sv
  - target: test
    files:
      - verif/mvau_stream_assertions.sv
      - verif/mvau_stream_tb.sv
